/* hw/pool_pkg.sv */
// sizes, data types and the method and state enums of the pooling stage
`default_nettype none

package pool_pkg;

  localparam int PIXEL_W    = 16;
  localparam int WORD_W     = 32;   // two pixels per stream word
  localparam int ACC_W      = 18;   // sum of two or four pixels fits here
  localparam int LINE_DEPTH = 128;  // max words per row
  localparam int LINE_AW    = $clog2(LINE_DEPTH);
  localparam int DIM_W      = 16;

  typedef logic        [WORD_W-1:0]  word_t;
  typedef logic signed [PIXEL_W-1:0] pixel_t;
  typedef logic signed [ACC_W-1:0]   acc_t;
  typedef logic        [DIM_W-1:0]   dim_t;

  typedef enum logic [1:0] {
    METHOD_MAX      = 2'd0,
    METHOD_AVG      = 2'd1,
    METHOD_DECIMATE = 2'd2,
    METHOD_BYPASS   = 2'd3
  } pool_method_e;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_BYPASS,
    ST_ROW_ODD,
    ST_ROW_EVEN,
    ST_DRAIN
  } pool_state_e;

endpackage

`default_nettype wire

/* hw/pool_reduce.sv */
// horizontal pixel-pair reduction and vertical combine with the stored partial value
`timescale 1ns/1ps
`default_nettype none

module pool_reduce (
  input  pool_pkg::pool_method_e method_i,
  input  pool_pkg::word_t        word_i,
  input  pool_pkg::acc_t         stored_i,   // partial value of the odd row, same column
  output pool_pkg::acc_t         odd_val_o,
  output pool_pkg::pixel_t       pooled_o
);

  pool_pkg::pixel_t lo_px;
  pool_pkg::pixel_t hi_px;
  pool_pkg::pixel_t pair_max;
  pool_pkg::pixel_t stored_px;
  pool_pkg::acc_t   pair_sum;
  pool_pkg::acc_t   quad_sum;
  pool_pkg::acc_t   quad_avg;

  assign lo_px = word_i[pool_pkg::PIXEL_W-1:0];              // left pixel
  assign hi_px = word_i[pool_pkg::WORD_W-1:pool_pkg::PIXEL_W];

  assign pair_max  = (hi_px > lo_px) ? hi_px : lo_px;
  assign pair_sum  = pool_pkg::acc_t'(lo_px) + pool_pkg::acc_t'(hi_px);
  assign stored_px = pool_pkg::pixel_t'(stored_i);

  // four pixels at most -131072..131068, still inside 18 bits
  assign quad_sum = stored_i + pair_sum;
  assign quad_avg = quad_sum >>> 2;                          // floor of sum / 4

  // odd row, one value per word into the line buffer
  always_comb begin
    case (method_i)
      pool_pkg::METHOD_AVG:      odd_val_o = pair_sum;
      pool_pkg::METHOD_DECIMATE: odd_val_o = pool_pkg::acc_t'(lo_px);
      default:                   odd_val_o = pool_pkg::acc_t'(pair_max);
    endcase
  end

  // even row, fold in the stored column value
  always_comb begin
    case (method_i)
      pool_pkg::METHOD_AVG:      pooled_o = pool_pkg::pixel_t'(quad_avg);
      pool_pkg::METHOD_DECIMATE: pooled_o = stored_px;       // low pixel of the odd-row word
      default: begin
        pooled_o = (pair_max > stored_px) ? pair_max : stored_px;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/pool_line_buffer.sv */
// one-row store of odd-row partial values, addressed by column
`timescale 1ns/1ps
`default_nettype none

module pool_line_buffer (
  input  logic           clk_gated,
  input  logic           rst_n,
  input  logic           we_i,
  input  pool_pkg::dim_t addr_i,
  input  pool_pkg::acc_t data_i,
  output pool_pkg::acc_t data_o
);

  pool_pkg::acc_t                  mem [pool_pkg::LINE_DEPTH];
  logic [pool_pkg::LINE_AW-1:0]    idx;

  // row length never exceeds LINE_DEPTH, upper column bits stay zero
  assign idx = addr_i[pool_pkg::LINE_AW-1:0];

  // odd rows write here, column by column
  always_ff @(posedge clk_gated) begin
    if (rst_n && we_i) begin                    // nothing is stored while held in reset
      mem[idx] <= data_i;
    end
  end

  // even rows read at the same column, no latency
  assign data_o = mem[idx];

endmodule

`default_nettype wire

/* hw/pool_ctrl.sv */
// pooling FSM with configuration latch, column and row counters and input ready
`timescale 1ns/1ps
`default_nettype none

module pool_ctrl (
  input  logic                   clk_gated,
  input  logic                   rst_n,
  input  logic                   start_i,
  input  pool_pkg::pool_method_e method_i,
  input  pool_pkg::dim_t         row_words_i,
  input  pool_pkg::dim_t         rows_i,
  input  logic                   in_valid_i,
  input  logic                   slot_free_i,
  input  logic                   out_valid_i,
  output logic                   in_ready_o,
  output logic                   busy_o,
  output pool_pkg::pool_method_e method_o,
  output pool_pkg::dim_t         col_o,
  output logic                   buf_we_o,
  output logic                   take_o,
  output logic                   pair_hi_o,
  output logic                   bypass_o
);

  pool_pkg::pool_state_e  state_q;
  pool_pkg::pool_state_e  state_d;
  pool_pkg::pool_method_e method_q;
  pool_pkg::dim_t         row_words_q;
  pool_pkg::dim_t         rows_q;
  pool_pkg::dim_t         col_q;
  pool_pkg::dim_t         row_q;
  logic                   accept;
  logic                   col_last;
  logic                   row_last;

  // input ready per state
  always_comb begin
    case (state_q)
      pool_pkg::ST_ROW_ODD:  in_ready_o = 1'b1;   // odd rows only fill the line buffer
      pool_pkg::ST_ROW_EVEN: in_ready_o = slot_free_i;
      pool_pkg::ST_BYPASS:   in_ready_o = slot_free_i;
      default:               in_ready_o = 1'b0;
    endcase
  end

  assign accept   = in_valid_i & in_ready_o;
  assign col_last = (col_q == row_words_q - 1'b1);
  assign row_last = (row_q == rows_q - 1'b1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      pool_pkg::ST_IDLE: begin
        if (start_i) begin
          if (method_i == pool_pkg::METHOD_BYPASS) begin
            state_d = pool_pkg::ST_BYPASS;
          end else begin
            state_d = pool_pkg::ST_ROW_ODD;
          end
        end
      end
      pool_pkg::ST_ROW_ODD: begin
        if (accept && col_last) begin
          state_d = pool_pkg::ST_ROW_EVEN;
        end
      end
      pool_pkg::ST_ROW_EVEN: begin
        if (accept && col_last) begin
          state_d = row_last ? pool_pkg::ST_DRAIN : pool_pkg::ST_ROW_ODD;
        end
      end
      pool_pkg::ST_BYPASS: begin
        if (accept && col_last && row_last) begin
          state_d = pool_pkg::ST_DRAIN;
        end
      end
      pool_pkg::ST_DRAIN: begin
        if (!out_valid_i) begin                    // last word handed off
          state_d = pool_pkg::ST_IDLE;
        end
      end
      default: state_d = pool_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      state_q     <= pool_pkg::ST_IDLE;
      method_q    <= pool_pkg::METHOD_MAX;
      row_words_q <= '0;
      rows_q      <= '0;
      col_q       <= '0;
      row_q       <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == pool_pkg::ST_IDLE && start_i) begin
        method_q    <= method_i;
        row_words_q <= row_words_i;
        rows_q      <= rows_i;
        col_q       <= '0;
        row_q       <= '0;
      end else if (accept) begin
        if (col_last) begin
          col_q <= '0;
          row_q <= row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  assign busy_o    = (state_q != pool_pkg::ST_IDLE);
  assign method_o  = method_q;
  assign col_o     = col_q;
  assign buf_we_o  = accept & (state_q == pool_pkg::ST_ROW_ODD);
  assign take_o    = accept & ((state_q == pool_pkg::ST_ROW_EVEN) |
                               (state_q == pool_pkg::ST_BYPASS));
  assign pair_hi_o = col_q[0] & (state_q == pool_pkg::ST_ROW_EVEN);  // odd column closes a pair
  assign bypass_o  = (state_q == pool_pkg::ST_BYPASS);

endmodule

`default_nettype wire

/* hw/pool_pack.sv */
// output pairing register, bypass register and output valid/ready
`timescale 1ns/1ps
`default_nettype none

module pool_pack (
  input  logic             clk_gated,
  input  logic             rst_n,
  input  logic             take_i,
  input  logic             pair_hi_i,
  input  logic             bypass_i,
  input  pool_pkg::pixel_t pixel_i,
  input  pool_pkg::word_t  word_i,
  input  logic             out_ready_i,
  output logic             slot_free_o,
  output logic             out_valid_o,
  output pool_pkg::word_t  out_data_o
);

  pool_pkg::pixel_t hold_q;     // first pooled pixel of the pair
  pool_pkg::word_t  out_q;
  logic             out_valid_q;
  logic             load;
  logic             hold_en;

  // a word lands in the output register on bypass or on the second pixel
  assign load    = take_i & (bypass_i | pair_hi_i);
  assign hold_en = take_i & ~bypass_i & ~pair_hi_i;

  // empty, or emptied on this edge
  assign slot_free_o = ~out_valid_q | out_ready_i;

  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_gated) begin
    if (hold_en) begin
      hold_q <= pixel_i;
    end
  end

  // loads only happen with a free slot, so back-pressure keeps the word
  always_ff @(posedge clk_gated) begin
    if (load) begin
      if (bypass_i) begin
        out_q <= word_i;                 // raw word
      end else begin
        out_q <= {pixel_i, hold_q};      // first result in the low half
      end
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_q;

endmodule

`default_nettype wire

/* hw/pool_top.sv */
// top level of the 2x2 pooling stage, controller, reduce, line buffer and packer
`timescale 1ns/1ps
`default_nettype none

module pool_top (
  input  logic                   clk_gated,
  input  logic                   rst_n,
  input  logic                   start_i,
  input  pool_pkg::pool_method_e method_i,
  input  pool_pkg::dim_t         row_words_i,
  input  pool_pkg::dim_t         rows_i,
  input  logic                   in_valid_i,
  input  pool_pkg::word_t        in_data_i,
  input  logic                   out_ready_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output pool_pkg::word_t        out_data_o,
  output logic                   busy_o
);

  pool_pkg::pool_method_e method;
  pool_pkg::dim_t         col;
  logic                   buf_we;
  logic                   take;
  logic                   pair_hi;
  logic                   bypass;
  logic                   slot_free;
  pool_pkg::acc_t         odd_val;
  pool_pkg::acc_t         stored;
  pool_pkg::pixel_t       pooled;

  pool_ctrl u_ctrl (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .method_i    (method_i),
    .row_words_i (row_words_i),
    .rows_i      (rows_i),
    .in_valid_i  (in_valid_i),
    .slot_free_i (slot_free),
    .out_valid_i (out_valid_o),     // drain ends when the packer is empty
    .in_ready_o  (in_ready_o),
    .busy_o      (busy_o),
    .method_o    (method),
    .col_o       (col),
    .buf_we_o    (buf_we),
    .take_o      (take),
    .pair_hi_o   (pair_hi),
    .bypass_o    (bypass)
  );

  pool_reduce u_reduce (
    .method_i  (method),
    .word_i    (in_data_i),
    .stored_i  (stored),
    .odd_val_o (odd_val),
    .pooled_o  (pooled)
  );

  pool_line_buffer u_line_buffer (
    .clk_gated (clk_gated),
    .rst_n     (rst_n),
    .we_i      (buf_we),
    .addr_i    (col),
    .data_i    (odd_val),
    .data_o    (stored)
  );

  pool_pack u_pack (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .take_i      (take),
    .pair_hi_i   (pair_hi),
    .bypass_i    (bypass),
    .pixel_i     (pooled),
    .word_i      (in_data_i),
    .out_ready_i (out_ready_i),
    .slot_free_o (slot_free),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

endmodule

`default_nettype wire

/* test/pool_tb_assert.sv */
// concurrent checks on the output handshake, idle input ready and reset state, with its bind
`timescale 1ns/1ps
`default_nettype none

module pool_tb_assert (
  input logic            clk_gated,
  input logic            rst_n,
  input logic            in_ready_i,
  input logic            out_valid_i,
  input pool_pkg::word_t out_data_i,
  input logic            out_ready_i,
  input logic            busy_i
);

  int fail_count = 0;  // failures so far

  // stalled output word holds until taken
  out_hold: assert property (@(posedge clk_gated) disable iff (!rst_n)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else begin
      fail_count++;
      $error("output word changed or dropped while out_ready_i was low");
    end

  idle_no_ready: assert property (@(posedge clk_gated) disable iff (!rst_n)
      !busy_i |-> !in_ready_i)
    else begin
      fail_count++;
      $error("in_ready_o high while busy_o low");
    end

  reset_no_valid: assert property (@(posedge clk_gated) !rst_n |=> !out_valid_i)
    else begin
      fail_count++;
      $error("out_valid_o high after a reset cycle");
    end

endmodule

bind pool_top pool_tb_assert u_assert (
  .clk_gated   (clk_gated),
  .rst_n       (rst_n),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_data_i  (out_data_o),
  .out_ready_i (out_ready_i),
  .busy_i      (busy_o)
);

`default_nettype wire

/* test/pool_tb.sv */
// table-driven testbench for the pooling stage, reference model, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

module pool_tb;

  typedef struct {
    pool_pkg::pool_method_e method;
    int words;       // words per row
    int rows;
    int valid_pct;
    int ready_pct;
    int exp_outs;    // output words per map
  } entry_t;

  localparam int N_ENTRIES = 9;

  logic                   clk_gated;
  logic                   rst_n;
  logic                   start_i;
  pool_pkg::pool_method_e method_i;
  pool_pkg::dim_t         row_words_i;
  pool_pkg::dim_t         rows_i;
  logic                   in_valid_i;
  pool_pkg::word_t        in_data_i;
  logic                   out_ready_i;
  logic                   in_ready_o;
  logic                   out_valid_o;
  pool_pkg::word_t        out_data_o;
  logic                   busy_o;

  entry_t          tbl [N_ENTRIES];
  pool_pkg::word_t exp_q [$];
  int got_count   = 0;
  int checks      = 0;
  int word_errs   = 0;
  int count_errs  = 0;
  int flag_errs   = 0;
  int other_errs  = 0;
  int cycles      = 0;
  int cycle_limit = 0;

  pool_top DUT (.*);

  initial begin
    clk_gated = 1'b0;
    forever #5 clk_gated = ~clk_gated;
  end

  task automatic check_word(input string name, input pool_pkg::word_t got,
                            input pool_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      word_errs++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input pool_pkg::dim_t got,
                             input pool_pkg::dim_t exp);
    checks++;
    if (got !== exp) begin
      count_errs++;
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      flag_errs++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  function automatic logic chance(input int pct);
    return ($urandom % 100) < pct;
  endfunction

  function automatic pool_pkg::pixel_t rand_pixel();
    case ($urandom % 6)
      0:       return 16'sh8000;   // most negative pixel
      1:       return 16'sh7fff;
      2:       return 16'shffff;
      default: return pool_pkg::pixel_t'($urandom);
    endcase
  endfunction

  // one 2x2 block from a top word of the odd row and a bottom word of the even row
  function automatic pool_pkg::pixel_t block_value(input pool_pkg::pool_method_e m,
                                                   input pool_pkg::word_t top_w,
                                                   input pool_pkg::word_t bot_w);
    int px [4];
    int best;
    int sum;
    px[0] = $signed(top_w[15:0]);
    px[1] = $signed(top_w[31:16]);
    px[2] = $signed(bot_w[15:0]);
    px[3] = $signed(bot_w[31:16]);
    best  = px[0];
    sum   = 0;
    for (int k = 0; k < 4; k++) begin
      if (px[k] > best) best = px[k];
      sum += px[k];
    end
    case (m)
      pool_pkg::METHOD_AVG:      return pool_pkg::pixel_t'(sum >>> 2);  // floor of sum / 4
      pool_pkg::METHOD_DECIMATE: return pool_pkg::pixel_t'(px[0]);
      default:                   return pool_pkg::pixel_t'(best);
    endcase
  endfunction

  task automatic build_expected(input entry_t e, input pool_pkg::word_t w [$]);
    int top;
    int bot;
    exp_q.delete();
    if (e.method == pool_pkg::METHOD_BYPASS) begin
      foreach (w[k]) exp_q.push_back(w[k]);
    end else begin
      for (int r = 0; r < e.rows; r += 2) begin
        for (int c = 0; c < e.words; c += 2) begin
          top = r * e.words + c;
          bot = top + e.words;                 // same column on the next row
          exp_q.push_back({block_value(e.method, w[top + 1], w[bot + 1]),
                           block_value(e.method, w[top], w[bot])});
        end
      end
    end
  endtask

  task automatic fill_table();
    tbl[0] = '{pool_pkg::METHOD_BYPASS,     4, 2, 100, 100,  8};
    tbl[1] = '{pool_pkg::METHOD_MAX,        8, 4, 100, 100,  8};
    tbl[2] = '{pool_pkg::METHOD_AVG,        6, 4,  80,  70,  6};
    tbl[3] = '{pool_pkg::METHOD_DECIMATE,   4, 2,  90,  90,  2};
    tbl[4] = '{pool_pkg::METHOD_MAX,       16, 6,  50,  40, 24};
    tbl[5] = '{pool_pkg::METHOD_AVG,       10, 4,  60,  50, 10};
    tbl[6] = '{pool_pkg::METHOD_BYPASS,     6, 4,  50,  50, 24};
    tbl[7] = '{pool_pkg::METHOD_DECIMATE,   8, 6,  70,  40, 12};
    tbl[8] = '{pool_pkg::METHOD_AVG,      128, 2,  90,  60, 64};  // full line depth
  endtask

  task automatic run_entry(input entry_t e);
    pool_pkg::word_t words [$];
    int   n;
    int   i;
    int   base;
    logic accepted;
    n = e.words * e.rows;
    for (i = 0; i < n; i++) words.push_back({rand_pixel(), rand_pixel()});
    build_expected(e, words);
    base        = got_count;
    start_i     = 1'b1;
    method_i    = e.method;
    row_words_i = pool_pkg::dim_t'(e.words);
    rows_i      = pool_pkg::dim_t'(e.rows);
    @(posedge clk_gated);
    #1;
    start_i = 1'b0;
    check_flag("busy_o", busy_o, 1'b1);
    i = 0;
    while (i < n) begin
      if (!in_valid_i && chance(e.valid_pct)) begin
        in_valid_i = 1'b1;
        in_data_i  = words[i];
      end
      out_ready_i = chance(e.ready_pct);
      @(posedge clk_gated);
      accepted = in_valid_i && in_ready_o;
      #1;
      if (accepted) begin
        i++;
        in_valid_i = 1'b0;
      end
    end
    while (busy_o) begin                      // drain the last output words
      out_ready_i = chance(e.ready_pct);
      @(posedge clk_gated);
      #1;
    end
    out_ready_i = 1'b0;
    check_count("pending words", pool_pkg::dim_t'(exp_q.size()), '0);
    check_count("output words", pool_pkg::dim_t'(got_count - base),
                pool_pkg::dim_t'(e.exp_outs));
    repeat (3) @(posedge clk_gated);
    #1;
    check_flag("in_ready_o", in_ready_o, 1'b0);   // still idle between entries
    check_flag("busy_o", busy_o, 1'b0);
  endtask

  // output monitor that compares each handed-off word with the model
  always @(posedge clk_gated) begin
    if (rst_n && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("output word %h at %0t ns arrived when none was expected", out_data_o, $time);
      end else begin
        check_word("out_data_o", out_data_o, exp_q.pop_front());
      end
      got_count++;
    end
  end

  always @(posedge clk_gated) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    int total;
    void'($urandom(98));
    rst_n       = 1'b0;
    start_i     = 1'b0;
    method_i    = pool_pkg::METHOD_MAX;
    row_words_i = '0;
    rows_i      = '0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    fill_table();
    foreach (tbl[k]) cycle_limit += tbl[k].words * tbl[k].rows * 8;
    cycle_limit += 200;
    repeat (16) @(posedge clk_gated);
    #1;
    rst_n = 1'b1;
    check_flag("in_ready_o", in_ready_o, 1'b0);
    check_flag("out_valid_o", out_valid_o, 1'b0);
    check_flag("busy_o", busy_o, 1'b0);
    foreach (tbl[k]) run_entry(tbl[k]);
    total = word_errs + count_errs + flag_errs + other_errs + DUT.u_assert.fail_count;
    $display("checks %0d, errors: word %0d, count %0d, flag %0d, other %0d, assertion %0d",
             checks, word_errs, count_errs, flag_errs, other_errs, DUT.u_assert.fail_count);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* pool_top.f */
hw/pool_pkg.sv
hw/pool_reduce.sv
hw/pool_line_buffer.sv
hw/pool_ctrl.sv
hw/pool_pack.sv
hw/pool_top.sv
test/pool_tb_assert.sv
test/pool_tb.sv

/* Bender.yml */
package:
  name: pool_top

sources:
  - files:
      - hw/pool_pkg.sv
      - hw/pool_reduce.sv
      - hw/pool_line_buffer.sv
      - hw/pool_ctrl.sv
      - hw/pool_pack.sv
      - hw/pool_top.sv
  - target: test
    files:
      - test/pool_tb_assert.sv
      - test/pool_tb.sv
